/* src.f */
+incdir+include
src/exu_pkg.sv
src/exu_issue_stage.sv
src/exu_alu.sv
src/exu_muldiv.sv
src/exu_result_stage.sv
src/exu_top.sv
tb/exu_tb.sv

/* Bender.yml */
package:
  name: exu

export_include_dirs:
  - include

sources:
  - src/exu_pkg.sv
  - src/exu_issue_stage.sv
  - src/exu_alu.sv
  - src/exu_muldiv.sv
  - src/exu_result_stage.sv
  - src/exu_top.sv
  - target: test
    files:
      - tb/exu_tb.sv

/* tb/exu_tests.txt */
// op word rs1 rs2 src_a src_b | mem wen rd data | wb wen rd data | rd expected, all hex
// op: 0 add 1 sub 2 slt 3 sltu 4 and 5 or 6 xor 7 sll 8 srl 9 sra a mul b div c divu d rem e remu
0 0 0 0 1 2 0 0 0 0 0 0 01 3
0 0 0 0 ffffffffffffffff 2 0 0 0 0 0 0 02 1
0 1 0 0 7fffffff 1 0 0 0 0 0 0 03 ffffffff80000000
1 0 0 0 5 7 0 0 0 0 0 0 04 fffffffffffffffe
1 1 0 0 100000000 1 0 0 0 0 0 0 05 ffffffffffffffff
2 0 0 0 ffffffffffffffff 1 0 0 0 0 0 0 06 1
3 0 0 0 ffffffffffffffff 1 0 0 0 0 0 0 07 0
4 0 0 0 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 0 0 0 0 0 0 08 0f000f000f000f00
5 0 0 0 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 0 0 0 0 0 0 09 ff0fff0fff0fff0f
6 0 0 0 ff00ff00ff00ff00 0f0f0f0f0f0f0f0f 0 0 0 0 0 0 0a f00ff00ff00ff00f
7 0 0 0 1 3f 0 0 0 0 0 0 0b 8000000000000000
7 1 0 0 1 1f 0 0 0 0 0 0 0c ffffffff80000000
7 1 0 0 1 23 0 0 0 0 0 0 0d 8
8 0 0 0 8000000000000000 3f 0 0 0 0 0 0 0e 1
8 1 0 0 80000000 20 0 0 0 0 0 0 0f ffffffff80000000
9 0 0 0 8000000000000000 3f 0 0 0 0 0 0 10 ffffffffffffffff
9 1 0 0 80000000 24 0 0 0 0 0 0 11 fffffffff8000000
9 1 0 0 ffffffff7fffffff 1f 0 0 0 0 0 0 12 0
a 0 0 0 3 5 0 0 0 0 0 0 13 f
a 0 0 0 ffffffffffffffff 7 0 0 0 0 0 0 14 fffffffffffffff9
a 1 0 0 ffff 10001 0 0 0 0 0 0 15 ffffffffffffffff
a 1 0 0 100000003 200000005 0 0 0 0 0 0 16 f
b 0 0 0 fffffffffffffff9 2 0 0 0 0 0 0 17 fffffffffffffffd
d 0 0 0 fffffffffffffff9 2 0 0 0 0 0 0 18 ffffffffffffffff
c 0 0 0 fffffffffffffff9 2 0 0 0 0 0 0 19 7ffffffffffffffc
b 0 0 0 1234 0 0 0 0 0 0 0 1a ffffffffffffffff
d 0 0 0 fffffffffffffff9 0 0 0 0 0 0 0 1b fffffffffffffff9
b 0 0 0 8000000000000000 ffffffffffffffff 0 0 0 0 0 0 1c 8000000000000000
d 0 0 0 8000000000000000 ffffffffffffffff 0 0 0 0 0 0 1d 0
b 1 0 0 fffffff9 2 0 0 0 0 0 0 1e fffffffffffffffd
b 1 0 0 80000000 ffffffff 0 0 0 0 0 0 1f ffffffff80000000
d 1 0 0 fffffff9 3 0 0 0 0 0 0 01 ffffffffffffffff
e 0 0 0 fffffffffffffff9 2 0 0 0 0 0 0 02 1
c 1 0 0 80000000 1 0 0 0 0 0 0 03 ffffffff80000000
0 0 3 0 1 10 1 3 100 0 0 0 04 110
0 0 4 0 1 1 1 4 1000 1 4 2000 05 1001
0 0 0 5 7 1 1 6 999 1 5 20 06 27
0 0 0 0 2 3 1 0 ffff 1 0 ffff 07 5
0 0 6 6 2 3 0 6 100 0 6 200 08 5
1 0 7 8 0 0 1 7 40 1 8 2 09 3e
a 0 9 9 0 0 1 9 6 0 0 0 0a 24

/* tb/exu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_tb;
    import exu_pkg::*;

    localparam int          RESET_CYC    = 10;
    localparam int          CYC_PER_TEST = 100;
    localparam logic [31:0] SEED         = 32'hbec10c4c;

    logic         clk = 1'b0;
    logic         arst_n;
    logic         in_valid;
    logic         in_ready;
    exu_req_t     in_req;
    exu_fwd_t     fwd_mem;
    exu_fwd_t     fwd_wb;
    logic         out_valid;
    logic         out_ready;
    exu_res_t     out_res;

    // one entry per vector line
    exu_req_t     req_v[$];
    exu_fwd_t     mem_v[$];
    exu_fwd_t     wb_v[$];
    exu_res_t     exp_v[$];
    // results still owed, oldest first
    exu_res_t     exp_q[$];

    int           err_cnt  = 0;
    int           n_pass   = 0;
    int           n_fail   = 0;
    int           n_done   = 0;
    logic         stall_en = 1'b0;
    logic [31:0]  stall_seed;

    exu_top exu_top_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .fwd_mem   (fwd_mem),
        .fwd_wb    (fwd_wb),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res)
    );

    always #5 clk = ~clk;

    // random back-pressure from downstream
    always @(posedge clk) begin
        if (stall_en) begin
            #1;
            stall_seed = lcg_next(stall_seed);
            out_ready  = stall_seed[31:30] != 2'b00;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_res(input string what, input exu_res_t got, input exu_res_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR @%0t: %s got rd %0d data %h, expected rd %0d data %h",
                     $time, what, got.rd, got.data, exp.rd, exp.data);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            n_pass++;
            $display("%s: ok", name);
        end else begin
            n_fail++;
            $display("%s: FAILED", name);
        end
    endtask

    task automatic load_tests();
        int                    fd;
        int                    cnt;
        string                 line;
        logic [`EXU_XLEN-1:0]  f [0:13];
        exu_req_t              req;
        exu_fwd_t              mem;
        exu_fwd_t              wb;
        exu_res_t              exp;
        fd = $fopen("tb/exu_tests.txt", "r");
        if (fd == 0) begin
            err_cnt++;
            $display("could not open tb/exu_tests.txt so no vectors were run");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt  = $fgets(line, fd);
                // column notes and blank lines carry no vector
                if (line.len() > 1 && line.substr(0, 1) != "//") begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                                  f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
                    if (cnt != 14) begin
                        err_cnt++;
                        $display("test file line has %0d fields instead of 14: %s", cnt, line);
                    end else begin
                        req.op    = exu_op_e'(f[0][`EXU_OP_W-1:0]);
                        req.word  = f[1][0];
                        req.rs1   = f[2][`EXU_REG_AW-1:0];
                        req.rs2   = f[3][`EXU_REG_AW-1:0];
                        req.src_a = f[4];
                        req.src_b = f[5];
                        req.rd    = f[12][`EXU_REG_AW-1:0];
                        mem.wen   = f[6][0];
                        mem.rd    = f[7][`EXU_REG_AW-1:0];
                        mem.data  = f[8];
                        wb.wen    = f[9][0];
                        wb.rd     = f[10][`EXU_REG_AW-1:0];
                        wb.data   = f[11];
                        exp.rd    = req.rd;
                        exp.data  = f[13];
                        req_v.push_back(req);
                        mem_v.push_back(mem);
                        wb_v.push_back(wb);
                        exp_v.push_back(exp);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // returns 1 ns after the edge that saw in_ready high
    task automatic wait_for_ready();
        logic took;
        do begin
            @(negedge clk);
            took = in_ready;
            @(posedge clk);
            #1;
        end while (!took);
    endtask

    task automatic startup_timing();
        exu_req_t req;
        exu_res_t exp;
        int       errs;
        errs = err_cnt;
        // first cycle out of reset
        @(posedge clk);
        #1;
        @(negedge clk);
        check_flag("in_ready after reset", in_ready, 1'b1);
        check_flag("out_valid after reset", out_valid, 1'b0);
        @(posedge clk);
        #1;
        req       = '0;
        req.op    = op_add;
        req.rd    = 5'd31;
        req.src_a = 64'h10;
        req.src_b = 64'h20;
        exp.rd    = 5'd31;
        exp.data  = 64'h30;
        in_req    = req;
        in_valid  = 1'b1;
        wait_for_ready();
        in_valid = 1'b0;
        // accept edge just passed, result register loads on the next one
        @(negedge clk);
        check_flag("out_valid before second edge", out_valid, 1'b0);
        @(negedge clk);
        check_flag("out_valid after second edge", out_valid, 1'b1);
        check_res("startup add", out_res, exp);
        @(posedge clk);
        #1;
        report_test("startup timing", errs);
    endtask

    task automatic drive_tests();
        logic [31:0] seed;
        seed = SEED;
        for (int i = 0; i < req_v.size(); i++) begin
            // idle cycles upstream
            seed = lcg_next(seed);
            while (seed[31:30] == 2'b00) begin
                @(posedge clk);
                #1;
                seed = lcg_next(seed);
            end
            in_req   = req_v[i];
            fwd_mem  = mem_v[i];
            fwd_wb   = wb_v[i];
            in_valid = 1'b1;
            exp_q.push_back(exp_v[i]);
            wait_for_ready();
            in_valid = 1'b0;
            // bypass sources stay put until the item leaves the issue register
            wait_for_ready();
        end
    endtask

    task automatic collect_results();
        exu_res_t held_res;
        exu_res_t exp;
        logic     held;
        int       errs;
        held = 1'b0;
        while (n_done < exp_v.size()) begin
            @(negedge clk);
            // stalled result must not move
            if (held) begin
                check_flag("out_valid under stall", out_valid, 1'b1);
                check_res("out_res under stall", out_res, held_res);
            end
            held     = out_valid && !out_ready;
            held_res = out_res;
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("result for rd %0d arrived with no test pending", out_res.rd);
                end else begin
                    errs = err_cnt;
                    exp  = exp_q.pop_front();
                    check_res($sformatf("test %0d", n_done + 1), out_res, exp);
                    n_done++;
                    report_test($sformatf("test %0d rd %0d", n_done, exp.rd), errs);
                end
            end
        end
    endtask

    initial begin : main
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_req     = '0;
        fwd_mem    = '0;
        fwd_wb     = '0;
        out_ready  = 1'b1;
        stall_seed = lcg_next(SEED);
        load_tests();
        // watchdog sized from the vector count
        fork
            begin
                repeat (RESET_CYC + CYC_PER_TEST * (exp_v.size() + 1)) @(posedge clk);
                $display("timeout with %0d of %0d results received", n_done, exp_v.size());
                $display("Done: errors found");
                $finish;
            end
        join_none
        repeat (RESET_CYC - 1) @(posedge clk);
        @(negedge clk);
        check_flag("in_ready during reset", in_ready, 1'b0);
        check_flag("out_valid during reset", out_valid, 1'b0);
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        startup_timing();
        stall_en = 1'b1;
        fork
            drive_tests();
            collect_results();
        join
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_pass + n_fail, n_pass, n_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/exu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_top (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     in_valid,
    output logic                    in_ready,
    input  wire exu_pkg::exu_req_t  in_req,
    input  wire exu_pkg::exu_fwd_t  fwd_mem,
    input  wire exu_pkg::exu_fwd_t  fwd_wb,
    output logic                    out_valid,
    input  wire                     out_ready,
    output exu_pkg::exu_res_t       out_res
);
    import exu_pkg::*;

    logic                  iss_valid;
    logic                  iss_ready;
    exu_req_t              iss_req;
    logic [`EXU_XLEN-1:0]  alu_data;
    logic                  md_claim;
    logic                  md_done;
    logic [`EXU_XLEN-1:0]  md_data;

    // input register with bypass
    exu_issue_stage exu_issue_stage_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .fwd_mem   (fwd_mem),
        .fwd_wb    (fwd_wb),
        .iss_valid (iss_valid),
        .iss_ready (iss_ready),
        .iss_req   (iss_req)
    );

    // both units see the same issued operands
    exu_alu exu_alu_inst (
        .iss_req  (iss_req),
        .alu_data (alu_data)
    );

    exu_muldiv exu_muldiv_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .iss_valid (iss_valid),
        .iss_req   (iss_req),
        .iss_ready (iss_ready),
        .md_claim  (md_claim),
        .md_done   (md_done),
        .md_data   (md_data)
    );

    exu_result_stage exu_result_stage_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .iss_valid (iss_valid),
        .iss_req   (iss_req),
        .iss_ready (iss_ready),
        .alu_data  (alu_data),
        .md_claim  (md_claim),
        .md_done   (md_done),
        .md_data   (md_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res)
    );

endmodule

`default_nettype wire

/* src/exu_result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_result_stage (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     iss_valid,
    input  wire exu_pkg::exu_req_t  iss_req,
    output logic                    iss_ready,
    input  wire [`EXU_XLEN-1:0]     alu_data,
    input  wire                     md_claim,
    input  wire                     md_done,
    input  wire [`EXU_XLEN-1:0]     md_data,
    output logic                    out_valid,
    input  wire                     out_ready,
    output exu_pkg::exu_res_t       out_res
);
    import exu_pkg::*;

    logic complete;

    // alu ops finish at once, mul/div waits for its unit
    assign complete  = iss_valid && (!md_claim || md_done);
    assign iss_ready = complete && (!out_valid || out_ready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (iss_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_ready) begin
            out_res.rd   <= iss_req.rd;
            out_res.data <= md_claim ? md_data : alu_data;
        end
    end

    // downstream stall freezes the output
    a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_res))
        else $error("output register changed under back-pressure");

endmodule

`default_nettype wire

/* src/exu_muldiv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_muldiv (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     iss_valid,
    input  wire exu_pkg::exu_req_t  iss_req,
    input  wire                     iss_ready,
    output logic                    md_claim,
    output logic                    md_done,
    output logic [`EXU_XLEN-1:0]    md_data
);
    import exu_pkg::*;

    md_state_e              state_q;
    logic [`EXU_CNT_W-1:0]  cnt_q;
    exu_op_e                op_q;
    logic                   word_q;
    logic                   q_neg_q;
    logic                   r_neg_q;
    // mul: product, shifting multiplicand, shifting multiplier
    // div: remainder, dividend/quotient, divisor
    logic [`EXU_XLEN-1:0]   acc_q;
    logic [`EXU_XLEN-1:0]   opa_q;
    logic [`EXU_XLEN-1:0]   opb_q;
    logic                   is_md;
    logic                   is_mul;
    logic                   sgn;
    logic                   start;
    logic                   a_neg;
    logic                   b_neg;
    logic                   b_zero;
    logic [`EXU_XLEN-1:0]   a_sel;
    logic [`EXU_XLEN-1:0]   b_sel;
    logic [`EXU_XLEN-1:0]   a_mag;
    logic [`EXU_XLEN-1:0]   b_mag;
    logic [`EXU_XLEN:0]     trial;
    logic [`EXU_XLEN-1:0]   res;

    assign is_md  = iss_req.op inside {op_mul, op_div, op_divu, op_rem, op_remu};
    assign is_mul = iss_req.op == op_mul;
    assign sgn    = iss_req.op inside {op_div, op_rem};

    assign md_claim = iss_valid && is_md;
    assign start    = md_claim && state_q == md_idle;
    // md_done port hides the enum literal, so name it via the package
    assign md_done  = state_q == exu_pkg::md_done;

    // operand magnitudes for the divider
    always_comb begin
        a_sel = iss_req.src_a;
        b_sel = iss_req.src_b;
        if (iss_req.word) begin
            a_sel = {{`EXU_WLEN{sgn && iss_req.src_a[31]}}, iss_req.src_a[31:0]};
            b_sel = {{`EXU_WLEN{sgn && iss_req.src_b[31]}}, iss_req.src_b[31:0]};
        end
        a_neg  = sgn && a_sel[`EXU_XLEN-1];
        b_neg  = sgn && b_sel[`EXU_XLEN-1];
        a_mag  = a_neg ? -a_sel : a_sel;
        b_mag  = b_neg ? -b_sel : b_sel;
        b_zero = b_sel == '0;
    end

    // one restoring step
    assign trial = {acc_q, opa_q[`EXU_XLEN-1]} - {1'b0, opb_q};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= md_idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                md_idle: begin
                    if (start) begin
                        state_q <= md_run;
                        cnt_q   <= iss_req.word ? `EXU_CNT_W'(`EXU_WLEN)
                                                : `EXU_CNT_W'(`EXU_XLEN);
                    end
                end
                md_run: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == `EXU_CNT_W'(1)) begin
                        state_q <= exu_pkg::md_done;
                    end
                end
                exu_pkg::md_done: begin
                    // held until the result stage takes it
                    if (iss_ready) begin
                        state_q <= md_idle;
                    end
                end
                default: state_q <= md_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q    <= iss_req.op;
            word_q  <= iss_req.word;
            // divide by zero keeps the all-ones quotient
            q_neg_q <= (a_neg ^ b_neg) && !b_zero;
            r_neg_q <= a_neg;
            acc_q   <= '0;
            if (is_mul) begin
                // low bits of the product ignore the sign
                opa_q <= iss_req.src_a;
                opb_q <= iss_req.src_b;
            end else begin
                // word dividend sits at the top so the msb shifts out first
                opa_q <= iss_req.word ? {a_mag[`EXU_WLEN-1:0], {`EXU_WLEN{1'b0}}} : a_mag;
                opb_q <= b_mag;
            end
        end else if (state_q == md_run) begin
            if (op_q == op_mul) begin
                if (opb_q[0]) begin
                    acc_q <= acc_q + opa_q;
                end
                opa_q <= opa_q << 1;
                opb_q <= opb_q >> 1;
            end else if (!trial[`EXU_XLEN]) begin
                acc_q <= trial[`EXU_XLEN-1:0];
                opa_q <= {opa_q[`EXU_XLEN-2:0], 1'b1};
            end else begin
                acc_q <= {acc_q[`EXU_XLEN-2:0], opa_q[`EXU_XLEN-1]};
                opa_q <= {opa_q[`EXU_XLEN-2:0], 1'b0};
            end
        end
    end

    // sign fix and word extension
    always_comb begin
        case (op_q)
            op_mul:          res = acc_q;
            // word quotient sits in the low half of opa
            op_div, op_divu: res = q_neg_q ? -opa_q : opa_q;
            // remainder takes the sign of the dividend
            default:         res = r_neg_q ? -acc_q : acc_q;
        endcase
        md_data = word_q ? {{`EXU_WLEN{res[`EXU_WLEN-1]}}, res[`EXU_WLEN-1:0]} : res;
    end

    // busy unit keeps seeing the op it started on
    a_md_claim_held: assert property (@(posedge clk) disable iff (!arst_n)
        state_q != md_idle |-> md_claim && iss_req.op == op_q)
        else $error("mul/div op left the issue register before its result was taken");

endmodule

`default_nettype wire

/* src/exu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_alu (
    input  wire exu_pkg::exu_req_t  iss_req,
    output logic [`EXU_XLEN-1:0]    alu_data
);
    import exu_pkg::*;

    logic [`EXU_XLEN-1:0]  a;
    logic [`EXU_XLEN-1:0]  b;
    logic [`EXU_WLEN-1:0]  a_lo;
    logic [5:0]            shamt;
    logic [`EXU_XLEN-1:0]  sra_d;
    logic [`EXU_WLEN-1:0]  sra_w;
    logic [`EXU_WLEN-1:0]  srl_w;
    logic [`EXU_XLEN-1:0]  raw;
    logic                  word_op;

    assign a    = iss_req.src_a;
    assign b    = iss_req.src_b;
    assign a_lo = a[`EXU_WLEN-1:0];

    // word shifts only look at 5 bits
    assign shamt = iss_req.word ? {1'b0, b[4:0]} : b[5:0];

    assign sra_d = $signed(a) >>> shamt;
    assign sra_w = $signed(a_lo) >>> shamt[4:0];
    assign srl_w = a_lo >> shamt[4:0];

    always_comb begin
        word_op = 1'b0;
        case (iss_req.op)
            op_add: begin
                raw     = a + b;
                word_op = iss_req.word;
            end
            op_sub: begin
                raw     = a - b;
                word_op = iss_req.word;
            end
            op_slt:  raw = {{(`EXU_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            op_sltu: raw = {{(`EXU_XLEN-1){1'b0}}, a < b};
            op_and:  raw = a & b;
            op_or:   raw = a | b;
            op_xor:  raw = a ^ b;
            op_sll: begin
                // low 32 bits of the wide shift are the word result
                raw     = a << shamt;
                word_op = iss_req.word;
            end
            op_srl: begin
                raw     = iss_req.word ? {{`EXU_WLEN{1'b0}}, srl_w} : a >> shamt;
                word_op = iss_req.word;
            end
            op_sra: begin
                raw     = iss_req.word ? {{`EXU_WLEN{1'b0}}, sra_w} : sra_d;
                word_op = iss_req.word;
            end
            // mul/div ops, result comes from the other unit
            default: raw = a + b;
        endcase
        alu_data = word_op ? {{`EXU_WLEN{raw[`EXU_WLEN-1]}}, raw[`EXU_WLEN-1:0]} : raw;
    end

endmodule

`default_nettype wire

/* src/exu_issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_issue_stage (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     in_valid,
    output logic                    in_ready,
    input  wire exu_pkg::exu_req_t  in_req,
    input  wire exu_pkg::exu_fwd_t  fwd_mem,
    input  wire exu_pkg::exu_fwd_t  fwd_wb,
    output logic                    iss_valid,
    input  wire                     iss_ready,
    output exu_pkg::exu_req_t       iss_req
);
    import exu_pkg::*;

    logic                  vld_q;
    logic                  rst_done_q;
    exu_req_t              req_q;
    logic [`EXU_XLEN-1:0]  fwd_a;
    logic [`EXU_XLEN-1:0]  fwd_b;

    // mem is younger than wb so it wins
    function automatic logic [`EXU_XLEN-1:0] bypass(
        input logic [`EXU_REG_AW-1:0] rs,
        input logic [`EXU_XLEN-1:0]   held,
        input exu_fwd_t               mem,
        input exu_fwd_t               wb
    );
        // x0 is hardwired to zero, never bypassed
        if (mem.wen && mem.rd == rs && rs != '0) begin
            return mem.data;
        end
        if (wb.wen && wb.rd == rs && rs != '0) begin
            return wb.data;
        end
        return held;
    endfunction

    assign fwd_a = bypass(req_q.rs1, req_q.src_a, fwd_mem, fwd_wb);
    assign fwd_b = bypass(req_q.rs2, req_q.src_b, fwd_mem, fwd_wb);

    always_comb begin
        iss_req       = req_q;
        iss_req.src_a = fwd_a;
        iss_req.src_b = fwd_b;
    end

    assign iss_valid = vld_q;
    // stays closed until the first edge out of reset
    assign in_ready  = rst_done_q && (!vld_q || iss_ready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q      <= 1'b0;
            rst_done_q <= 1'b0;
        end else begin
            rst_done_q <= 1'b1;
            if (in_ready) begin
                vld_q <= in_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            req_q <= in_req;
        end else begin
            // keep the bypassed operands once the producer has retired
            req_q.src_a <= fwd_a;
            req_q.src_b <= fwd_b;
        end
    end

    // held instruction must not drift while the result stage stalls
    a_iss_hold: assert property (@(posedge clk) disable iff (!arst_n)
        iss_valid && !iss_ready |=> iss_valid && $stable(iss_req))
        else $error("issue register changed under stall");

endmodule

`default_nettype wire

/* src/exu_pkg.sv */
`default_nettype none

`include "exu_settings.svh"

package exu_pkg;

    // operations handled by the execute stage
    typedef enum logic [`EXU_OP_W-1:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_slt  = 4'd2,
        op_sltu = 4'd3,
        op_and  = 4'd4,
        op_or   = 4'd5,
        op_xor  = 4'd6,
        op_sll  = 4'd7,
        op_srl  = 4'd8,
        op_sra  = 4'd9,
        // iterative unit from here on
        op_mul  = 4'd10,
        op_div  = 4'd11,
        op_divu = 4'd12,
        op_rem  = 4'd13,
        op_remu = 4'd14
    } exu_op_e;

    // mul/div sequencer
    typedef enum logic [1:0] {
        md_idle = 2'd0,
        md_run  = 2'd1,
        md_done = 2'd2
    } md_state_e;

    // one instruction as handed over by decode
    typedef struct packed {
        exu_op_e                 op;
        logic                    word;
        logic [`EXU_REG_AW-1:0]  rd;
        logic [`EXU_REG_AW-1:0]  rs1;
        logic [`EXU_REG_AW-1:0]  rs2;
        logic [`EXU_XLEN-1:0]    src_a;
        logic [`EXU_XLEN-1:0]    src_b;
    } exu_req_t;

    // bypass source from mem or wb
    typedef struct packed {
        logic                    wen;
        logic [`EXU_REG_AW-1:0]  rd;
        logic [`EXU_XLEN-1:0]    data;
    } exu_fwd_t;

    // finished result towards mem
    typedef struct packed {
        logic [`EXU_REG_AW-1:0]  rd;
        logic [`EXU_XLEN-1:0]    data;
    } exu_res_t;

endpackage

`default_nettype wire

/* include/exu_settings.svh */
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// integer register width
`define EXU_XLEN 64

// width of the *w instruction variants
`define EXU_WLEN 32

// architectural register index
`define EXU_REG_AW 5

// opcode enum width
`define EXU_OP_W 4

// mul/div step counter, must reach EXU_XLEN
`define EXU_CNT_W 7

`endif
